// ==== kernel_apb_regs.sv ====
`timescale 1ns/1ns

module kernel_apb_regs
  import tytra_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  apb_addr_t paddr,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  input  gl_cntr_t  gl_cntr,
  input  apb_data_t results,
  output logic      run,
  output logic      hold,
  output logic      clear
);

  logic access;
  logic addr_ok;
  logic ctrl_wr;

  // ==========================================================================
  // decode
  // ==========================================================================

  // access phase, zero wait states
  assign access  = psel && penable;
  assign addr_ok = (paddr == ADDR_CTRL) || (paddr == ADDR_GLCNT) ||
                   (paddr == ADDR_RESULTS);
  assign ctrl_wr = access && pwrite && (paddr == ADDR_CTRL);

  assign pready  = 1'b1;
  // unmapped offset
  assign pslverr = access && !addr_ok;

  // ==========================================================================
  // control register
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      run   <= 1'b0;
      hold  <= 1'b0;
      clear <= 1'b0;
    end else begin
      // clear is a pulse
      clear <= 1'b0;
      if (ctrl_wr) begin
        run   <= pwdata[CTRL_RUN_BIT];
        hold  <= pwdata[CTRL_HOLD_BIT];
        clear <= pwdata[CTRL_CLEAR_BIT];
      end
    end
  end

  // ==========================================================================
  // read mux
  // ==========================================================================

  always_comb begin
    prdata = '0;
    case (paddr)
      ADDR_CTRL: begin
        prdata[CTRL_RUN_BIT]   = run;
        prdata[CTRL_HOLD_BIT]  = hold;
        prdata[CTRL_CLEAR_BIT] = clear;
      end
      // counter zero-extended
      ADDR_GLCNT:   prdata = apb_data_t'(gl_cntr);
      ADDR_RESULTS: prdata = results;
      default:      prdata = '0;
    endcase
  end

  // error only inside a transfer
  slverr_in_access: assert property (
    @(posedge clk) disable iff (rst)
    pslverr |-> (psel && penable)
  ) else $error("kernel_apb_regs: pslverr outside access phase");

endmodule

// ==== kernel_pipe.sv ====
`timescale 1ns/1ns

module kernel_pipe
  import tytra_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  sched_if.node      ctl,
  input  data_word_t in_data,
  input  logic       in_valid,
  output logic       in_ready,
  output data_word_t out_data,
  output logic       out_valid,
  output apb_data_t  results
);

  data_word_t n0_data;
  logic       n0_valid;
  data_word_t n1_data;
  logic       n1_valid;
  logic       fire1;
  logic       fire2;
  apb_data_t  results_q;

  // ==========================================================================
  // node chain
  // ==========================================================================

  // node 0 takes the stream, its fire is the input handshake
  map_node #(
    .LAT (NODE0_LAT),
    .SD  (1),
    .OP  (op_inc)
  ) u_node0 (
    .clk        (clk),
    .rst        (rst),
    .ctl        (ctl),
    .din        (in_data),
    .din_valid  (in_valid),
    .fire       (in_ready),
    .dout       (n0_data),
    .dout_valid (n0_valid)
  );

  // starts once node 0 output holds its first item
  map_node #(
    .LAT (NODE1_LAT),
    .SD  (1 + NODE0_LAT),
    .OP  (op_shl)
  ) u_node1 (
    .clk        (clk),
    .rst        (rst),
    .ctl        (ctl),
    .din        (n0_data),
    .din_valid  (n0_valid),
    .fire       (fire1),
    .dout       (n1_data),
    .dout_valid (n1_valid)
  );

  map_node #(
    .LAT (NODE2_LAT),
    .SD  (1 + NODE0_LAT + NODE1_LAT),
    .OP  (op_add3)
  ) u_node2 (
    .clk        (clk),
    .rst        (rst),
    .ctl        (ctl),
    .din        (n1_data),
    .din_valid  (n1_valid),
    .fire       (fire2),
    .dout       (out_data),
    .dout_valid (out_valid)
  );

  // ==========================================================================
  // result count
  // ==========================================================================

  // a valid output leaves when node 2 fires over it
  always_ff @(posedge clk) begin
    if (rst || ctl.clear) begin
      results_q <= '0;
    end else if (fire2 && out_valid) begin
      results_q <= results_q + 1'b1;
    end
  end

  assign results = results_q;

  // later nodes start later and never fire alone
  fire_order: assert property (
    @(posedge clk) disable iff (rst)
    (fire1 || fire2) |-> (fire1 && in_ready)
  ) else $error("kernel_pipe: node fired ahead of its producer");

endmodule

// ==== kernel_sched.sv ====
`timescale 1ns/1ns

module kernel_sched
  import tytra_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   run,
  input  logic   hold,
  input  logic   clear,
  input  logic   out_ready,
  sched_if.sched sched
);

  logic     stall;
  gl_cntr_t gl_cntr_q;

  // ==========================================================================
  // stall
  // ==========================================================================

  // stopped, held by software, or sink not ready
  assign stall = !run || hold || !out_ready;

  // ==========================================================================
  // global counter
  // ==========================================================================

  // one step per unstalled cycle, saturating
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      gl_cntr_q <= '0;
    end else if (!stall && (gl_cntr_q != '1)) begin
      gl_cntr_q <= gl_cntr_q + 1'b1;
    end
  end

  // to the nodes
  assign sched.gl_cntr = gl_cntr_q;
  assign sched.stall   = stall;
  assign sched.run     = run;
  assign sched.clear   = clear;

  // time base frozen under stall
  gl_frozen_in_stall: assert property (
    @(posedge clk) disable iff (rst)
    (stall && !clear) |=> $stable(gl_cntr_q)
  ) else $error("kernel_sched: gl_cntr moved during stall");

endmodule

// ==== map_node.sv ====
`timescale 1ns/1ns

module map_node
  import tytra_pkg::*;
#(
  parameter int       LAT = 1,
  parameter int       SD  = 1,
  parameter node_op_e OP  = op_inc
) (
  input  logic       clk,
  input  logic       rst,
  sched_if.node      ctl,
  input  data_word_t din,
  input  logic       din_valid,
  output logic       fire,
  output data_word_t dout,
  output logic       dout_valid
);

  logic                   active;
  logic                   start_hit;
  logic                   fi_hit;
  logic [KERNEL_FI_W-1:0] fi_cntr;
  data_word_t             op_result;
  data_word_t             lat_data [LAT];
  logic [LAT-1:0]         lat_valid;

  // ==========================================================================
  // activation and firing
  // ==========================================================================

  // starting delay reached on the global counter
  assign start_hit = (ctl.gl_cntr == gl_cntr_t'(SD - 1));
  // firing interval elapsed
  assign fi_hit    = (fi_cntr == KERNEL_FI_LAST);

  // first fire from the counter, later fires from the fi counter
  // no firing in the clear cycle, the lines are being emptied
  assign fire = !ctl.stall && !ctl.clear && (active ? fi_hit : start_hit);

  // active from first fire until clear
  always_ff @(posedge clk) begin
    if (rst || ctl.clear) begin
      active <= 1'b0;
    end else if (fire) begin
      active <= 1'b1;
    end
  end

  // cycles since last fire, frozen under stall
  always_ff @(posedge clk) begin
    if (rst || ctl.clear) begin
      fi_cntr <= '0;
    end else if (fire) begin
      fi_cntr <= '0;
    end else if (active && !ctl.stall) begin
      fi_cntr <= fi_cntr + 1'b1;
    end
  end

  // ==========================================================================
  // operation and latency line
  // ==========================================================================

  always_comb begin
    case (OP)
      op_inc:  op_result = din + 32'd1;
      op_shl:  op_result = din << 1;
      op_add3: op_result = din + 32'd3;
      default: op_result = din;
    endcase
  end

  // valid bits, emptied on clear
  always_ff @(posedge clk) begin
    if (rst || ctl.clear) begin
      lat_valid <= '0;
    end else if (fire) begin
      lat_valid[0] <= din_valid;
      for (int i = 1; i < LAT; i++) begin
        lat_valid[i] <= lat_valid[i-1];
      end
    end
  end

  // data stages, one shift per fire
  always_ff @(posedge clk) begin
    if (fire) begin
      lat_data[0] <= op_result;
      for (int i = 1; i < LAT; i++) begin
        lat_data[i] <= lat_data[i-1];
      end
    end
  end

  // last stage is the node output
  assign dout       = lat_data[LAT-1];
  assign dout_valid = lat_valid[LAT-1];

  // fire only in an unstalled cycle of a running kernel
  fire_needs_run: assert property (
    @(posedge clk) disable iff (rst)
    fire |-> (!ctl.stall && ctl.run)
  ) else $error("map_node: fire while stalled or stopped");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_tytra_kernel \
  --Mdir obj_dir -o sim_tytra_kernel \
  -f tytra_kernel_top.f

./obj_dir/sim_tytra_kernel | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// ==== sched_if.sv ====
`timescale 1ns/1ns

interface sched_if
  import tytra_pkg::*;
();

  // global firing counter, common time base for all nodes
  gl_cntr_t gl_cntr;
  // kernel-wide stall
  logic     stall;
  // run state as seen by the nodes
  logic     run;
  // one-cycle clear pulse
  logic     clear;

  // scheduler side
  modport sched (
    output gl_cntr,
    output stall,
    output run,
    output clear
  );

  // pipeline side
  modport node (
    input gl_cntr,
    input stall,
    input run,
    input clear
  );

endinterface

// ==== tb_tytra_kernel.sv ====
`timescale 1ns/1ns

module tb_tytra_kernel
  import tytra_pkg::*;
();

  // cycles any single wait may take
  localparam int WAIT_LIMIT = 200;
  // firings from node 0 input to node 2 output
  localparam int PIPE_DEPTH = NODE0_LAT + NODE1_LAT + NODE2_LAT;

  logic       clk;
  logic       rst;
  apb_addr_t  paddr;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_data_t  pwdata;
  apb_data_t  prdata;
  logic       pready;
  logic       pslverr;
  data_word_t in_data;
  logic       in_valid;
  logic       in_ready;
  data_word_t out_data;
  logic       out_valid;
  logic       out_ready;

  // words taken by node 0, oldest first
  data_word_t pending [$];
  int         n_errors;
  int         n_timeouts;
  int         n_compared;
  // random back-pressure on out_ready
  logic       bp_en;
  logic       prev_ready_low;
  logic       prev_valid;
  data_word_t prev_data;
  apb_data_t  rd_a;
  apb_data_t  rd_b;
  logic       rd_err;

  tytra_kernel_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ==========================================================================
  // reference and compare
  // ==========================================================================

  // inc, then shl, then add3 gives 2x + 5, wrapping at 32 bits
  function automatic data_word_t expected_result(input data_word_t w);
    return w + w + 32'd5;
  endfunction

  function automatic apb_data_t ctrl_word(input logic run, input logic hold, input logic clear);
    apb_data_t w;
    w = '0;
    w[CTRL_RUN_BIT]   = run;
    w[CTRL_HOLD_BIT]  = hold;
    w[CTRL_CLEAR_BIT] = clear;
    return w;
  endfunction

  task automatic check_word(input string name, input data_word_t got, input data_word_t exp);
    if (got !== exp) begin
      n_errors = n_errors + 1;
      $display("[ERROR] %0t %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      n_errors = n_errors + 1;
      $display("[ERROR] %0t %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      n_errors = n_errors + 1;
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    n_timeouts = n_timeouts + 1;
    $display("timeout at %0t while waiting for %s", $time, what);
  endtask

  // ==========================================================================
  // apb master
  // ==========================================================================

  // setup then access phase, starts and ends 2 ns after an edge
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    int waited;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #2;
    penable = 1'b1;
    waited  = 0;
    @(negedge clk);
    while (!pready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited = waited + 1;
    end
    if (!pready) begin
      report_timeout("pready");
    end
    // zero wait states, ready in the first access cycle
    check_bit("pready", pready, 1'b1);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t unused_data;
    logic      unused_err;
    apb_access(1'b1, addr, data, unused_data, unused_err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  // ==========================================================================
  // stream driver and monitor
  // ==========================================================================

  // random words with an occasional bubble
  task automatic send_burst(input int count);
    int   waited;
    logic taken;
    for (int i = 0; i < count; i++) begin
      if ($urandom % 4 == 0) begin
        in_valid = 1'b0;
        @(posedge clk);
        #2;
      end
      in_data  = $urandom;
      in_valid = 1'b1;
      waited   = 0;
      taken    = 1'b0;
      while (!taken && waited < WAIT_LIMIT) begin
        @(negedge clk);
        taken = in_ready;
        @(posedge clk);
        #2;
        waited = waited + 1;
      end
      if (!taken) begin
        report_timeout("in_ready");
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending.size() != 0 && waited < WAIT_LIMIT + PIPE_DEPTH) begin
      @(posedge clk);
      #2;
      waited = waited + 1;
    end
    if (pending.size() != 0) begin
      report_timeout("the last results to leave");
    end
  endtask

  // word taken at the coming edge
  always @(negedge clk) begin
    if (!rst && in_valid && in_ready) begin
      pending.push_back(in_data);
    end
  end

  // sink side, randomly not ready while bp_en
  always @(posedge clk) begin
    #2;
    if (bp_en) begin
      out_ready = ($urandom % 3) != 0;
    end else begin
      out_ready = 1'b1;
    end
  end

  always @(negedge clk) begin
    data_word_t exp_w;
    if (!rst) begin
      // nothing fires under back-pressure
      if (prev_ready_low && prev_valid) begin
        check_word("out_data held", out_data, prev_data);
        check_bit("out_valid held", out_valid, 1'b1);
      end
      if (!out_ready) begin
        check_bit("in_ready under back-pressure", in_ready, 1'b0);
      end
      // node 2 fires with node 0 once running, so in_ready marks the handshake
      if (out_valid && out_ready && in_ready) begin
        if (pending.size() == 0) begin
          n_errors = n_errors + 1;
          $display("result %08h at %0t came with no input pending", out_data, $time);
        end else begin
          exp_w = expected_result(pending.pop_front());
          check_word("out_data", out_data, exp_w);
          n_compared = n_compared + 1;
        end
      end
      prev_ready_low = !out_ready;
      prev_valid     = out_valid;
      prev_data      = out_data;
    end
  end

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    paddr          = '0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    pwdata         = '0;
    in_data        = '0;
    in_valid       = 1'b0;
    out_ready      = 1'b1;
    bp_en          = 1'b0;
    n_errors       = 0;
    n_timeouts     = 0;
    n_compared     = 0;
    prev_ready_low = 1'b0;
    prev_valid     = 1'b0;
    prev_data      = '0;
    void'($urandom(32'h3feba03f));
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;

    // idle after reset
    @(negedge clk);
    check_bit("in_ready after reset", in_ready, 1'b0);
    check_bit("out_valid after reset", out_valid, 1'b0);
    check_bit("pslverr after reset", pslverr, 1'b0);
    @(posedge clk);
    #2;
    apb_read(ADDR_GLCNT, rd_a, rd_err);
    check_reg("glcnt after reset", rd_a, '0);

    // plain burst
    apb_write(ADDR_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
    send_burst(40);
    wait_drain();
    apb_read(ADDR_RESULTS, rd_a, rd_err);
    check_reg("results register", rd_a, 32'd40);

    // burst under random back-pressure
    bp_en = 1'b1;
    send_burst(40);
    wait_drain();
    bp_en = 1'b0;
    apb_read(ADDR_RESULTS, rd_a, rd_err);
    check_reg("results register", rd_a, 32'd80);

    // hold freezes the kernel, release resumes it
    apb_write(ADDR_CTRL, ctrl_word(1'b1, 1'b1, 1'b0));
    fork
      send_burst(12);
      begin
        apb_read(ADDR_GLCNT, rd_a, rd_err);
        repeat (3) @(posedge clk);
        #2;
        apb_read(ADDR_GLCNT, rd_b, rd_err);
        check_reg("glcnt under hold", rd_b, rd_a);
        @(negedge clk);
        check_bit("in_ready under hold", in_ready, 1'b0);
        @(posedge clk);
        #2;
        apb_write(ADDR_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
      end
    join
    wait_drain();
    apb_read(ADDR_RESULTS, rd_a, rd_err);
    check_reg("results register", rd_a, 32'd92);

    // result count, then clear with the kernel stopped
    apb_read(ADDR_RESULTS, rd_a, rd_err);
    check_reg("results register", rd_a, apb_data_t'(n_compared));
    apb_write(ADDR_CTRL, ctrl_word(1'b0, 1'b0, 1'b0));
    apb_write(ADDR_CTRL, ctrl_word(1'b0, 1'b0, 1'b1));
    apb_read(ADDR_GLCNT, rd_a, rd_err);
    check_reg("glcnt after clear", rd_a, '0);
    apb_read(ADDR_RESULTS, rd_a, rd_err);
    check_reg("results after clear", rd_a, '0);
    n_compared = 0;
    apb_write(ADDR_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
    send_burst(20);
    wait_drain();
    apb_read(ADDR_RESULTS, rd_a, rd_err);
    check_reg("results register", rd_a, apb_data_t'(n_compared));
    check_reg("results register", rd_a, 32'd20);

    // address decode
    apb_read(8'h0c, rd_a, rd_err);
    check_bit("pslverr unmapped", rd_err, 1'b1);
    apb_read(ADDR_CTRL, rd_a, rd_err);
    check_bit("pslverr mapped", rd_err, 1'b0);
    check_reg("ctrl readback", rd_a, ctrl_word(1'b1, 1'b0, 1'b0));

    $display("results compared %0d, errors %0d, timeouts %0d",
             n_compared, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== tytra_kernel_top.f ====
tytra_pkg.sv
sched_if.sv
map_node.sv
kernel_pipe.sv
kernel_sched.sv
kernel_apb_regs.sv
tytra_kernel_top.sv
tb_tytra_kernel.sv

// ==== tytra_kernel_top.sv ====
`timescale 1ns/1ns

module tytra_kernel_top
  import tytra_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // apb control port
  input  apb_addr_t  paddr,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  apb_data_t  pwdata,
  output apb_data_t  prdata,
  output logic       pready,
  output logic       pslverr,
  // input stream
  input  data_word_t in_data,
  input  logic       in_valid,
  output logic       in_ready,
  // output stream
  output data_word_t out_data,
  output logic       out_valid,
  input  logic       out_ready
);

  logic      run;
  logic      hold;
  logic      clear;
  apb_data_t results;

  // scheduler to pipeline
  sched_if u_sched_if ();

  // ==========================================================================
  // software control
  // ==========================================================================

  kernel_apb_regs u_regs (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .gl_cntr (u_sched_if.gl_cntr),
    .results (results),
    .run     (run),
    .hold    (hold),
    .clear   (clear)
  );

  // ==========================================================================
  // scheduler and dataflow
  // ==========================================================================

  kernel_sched u_sched (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .hold      (hold),
    .clear     (clear),
    .out_ready (out_ready),
    .sched     (u_sched_if.sched)
  );

  kernel_pipe u_pipe (
    .clk       (clk),
    .rst       (rst),
    .ctl       (u_sched_if.node),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .results   (results)
  );

endmodule

// ==== tytra_pkg.sv ====
package tytra_pkg;

  // ==========================================================================
  // word types
  // ==========================================================================

  // data word flowing node to node
  typedef logic [31:0] data_word_t;
  // global firing counter
  typedef logic [15:0] gl_cntr_t;
  // apb bus fields
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // node operations
  typedef enum logic [1:0] {
    op_inc,
    op_shl,
    op_add3
  } node_op_e;

  // ==========================================================================
  // kernel constants
  // ==========================================================================

  // single-rate kernel, every node fires each unstalled cycle
  localparam int KERNEL_AFI = 1;
  // fi counter width, never below one bit
  localparam int KERNEL_FI_W = (KERNEL_AFI > 1) ? $clog2(KERNEL_AFI) : 1;
  // terminal count of the fi counter
  localparam logic [KERNEL_FI_W-1:0] KERNEL_FI_LAST = KERNEL_FI_W'(KERNEL_AFI - 1);

  // node latencies in firings
  localparam int NODE0_LAT = 1;
  localparam int NODE1_LAT = 3;
  localparam int NODE2_LAT = 2;

  // ==========================================================================
  // register map
  // ==========================================================================

  localparam apb_addr_t ADDR_CTRL    = 8'h00;
  localparam apb_addr_t ADDR_GLCNT   = 8'h04;
  localparam apb_addr_t ADDR_RESULTS = 8'h08;

  // control register bits
  localparam int CTRL_RUN_BIT   = 0;
  localparam int CTRL_HOLD_BIT  = 1;
  localparam int CTRL_CLEAR_BIT = 2;

endpackage
